// ==== src/dvi_pkg.sv ====
// ======================================================================
// Shared timing constants, TMDS control symbols and configuration types
// for the 640x480 DVI transmitter. Imported by every design module.
// ======================================================================
`default_nettype none

package dvi_pkg;

    // Horizontal timing in pixel clocks
    localparam logic [9:0] h_active = 10'd640;
    localparam logic [9:0] h_front  = 10'd16;
    localparam logic [9:0] h_sync   = 10'd96;
    localparam logic [9:0] h_back   = 10'd48;
    localparam logic [9:0] h_total  = h_active + h_front + h_sync + h_back;

    // Vertical timing in lines
    localparam logic [9:0] v_active = 10'd480;
    localparam logic [9:0] v_front  = 10'd10;
    localparam logic [9:0] v_sync   = 10'd2;
    localparam logic [9:0] v_back   = 10'd33;
    localparam logic [9:0] v_total  = v_active + v_front + v_sync + v_back;

    // Sync windows, start inclusive and end exclusive
    localparam logic [9:0] h_sync_start = h_active + h_front;
    localparam logic [9:0] h_sync_end   = h_sync_start + h_sync;
    localparam logic [9:0] v_sync_start = v_active + v_front;
    localparam logic [9:0] v_sync_end   = v_sync_start + v_sync;

    // TMDS control symbols, index is {c1, c0}
    localparam logic [9:0] ctl_sym_0 = 10'b1101010100;
    localparam logic [9:0] ctl_sym_1 = 10'b0010101011;
    localparam logic [9:0] ctl_sym_2 = 10'b0101010100;
    localparam logic [9:0] ctl_sym_3 = 10'b1010101011;

    // Encoder delay from inputs to symbol
    localparam int enc_latency = 3;

    // Width of one colour bar
    localparam logic [9:0] bar_width = 10'd80;

    // Test pattern selection, code 3 is not a legal mode
    typedef enum logic [1:0] {
        pat_bars  = 2'd0,
        pat_solid = 2'd1,
        pat_ramp  = 2'd2
    } pattern_t;

    // Configuration register map
    typedef enum logic {
        addr_mode  = 1'b0,
        addr_color = 1'b1
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== src/video_timing.sv ====
// ======================================================================
// Raster timing for 640x480 at 60 Hz. Produces registered coordinates,
// active-video flag and positive hsync and vsync one clock after the count.
// ======================================================================
`default_nettype none

module video_timing import dvi_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    output logic [9:0]      hpos,
    output logic [9:0]      vpos,
    output logic            active,
    output logic            hsync,
    output logic            vsync
);

    // Free running raster position
    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_last;
    logic       v_last;

    assign h_last = (h_cnt == h_total - 10'd1);
    assign v_last = (v_cnt == v_total - 10'd1);

    // Pixel and line counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                // Line wraps at the end of the frame
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 10'd1;
                end
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end
        end
    end

    // Outputs follow the counters by one clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hpos   <= '0;
            vpos   <= '0;
            active <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else begin
            hpos   <= h_cnt;
            vpos   <= v_cnt;
            active <= (h_cnt < h_active) && (v_cnt < v_active);
            hsync  <= (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
            // Vsync spans whole lines
            vsync  <= (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);
        end
    end

    // Coordinate output must stay inside the line
    a_hpos_range: assert property (@(posedge clk) disable iff (!rst_n)
        hpos < h_total);

endmodule

`default_nettype wire

// ==== src/dvi_regs.sv ====
// ======================================================================
// Configuration registers for the pattern generator. Written with a
// single-cycle strobe, no acknowledge; values reach the video path next clock.
// ======================================================================
`default_nettype none

module dvi_regs import dvi_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        cfg_we,
    input  wire reg_addr_t   cfg_addr,
    input  wire logic [23:0] cfg_wdata,
    output pattern_t         mode,
    output logic [23:0]      color
);

    // Only the three defined pattern codes are accepted
    logic mode_ok;

    assign mode_ok = (cfg_wdata[1:0] == pat_bars)  ||
                     (cfg_wdata[1:0] == pat_solid) ||
                     (cfg_wdata[1:0] == pat_ramp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode  <= pat_bars;
            color <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                addr_mode: begin
                    // Illegal code keeps the previous mode
                    if (mode_ok) begin
                        mode <= pattern_t'(cfg_wdata[1:0]);
                    end
                end
                addr_color: begin
                    // Red in 23:16, green in 15:8, blue in 7:0
                    color <= cfg_wdata;
                end
            endcase
        end
    end

    // Stored mode is always one of the legal patterns
    a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (mode == pat_bars) || (mode == pat_solid) || (mode == pat_ramp));

endmodule

`default_nettype wire

// ==== src/pattern_gen.sv ====
// ======================================================================
// Test-pattern pixel source. One registered RGB pixel per clock from the
// raster coordinates and the configured mode and colour.
// ======================================================================
`default_nettype none

module pattern_gen import dvi_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [9:0]  hpos,
    input  wire logic [9:0]  vpos,
    input  wire pattern_t    mode,
    input  wire logic [23:0] color,
    output logic [7:0]       red,
    output logic [7:0]       green,
    output logic [7:0]       blue
);

    logic [9:0] bar_idx;
    logic [2:0] bar_rgb;
    logic [7:0] red_next;
    logic [7:0] green_next;
    logic [7:0] blue_next;

    // Eight bars across the visible line
    assign bar_idx = hpos / bar_width;

    // Order white, yellow, cyan, green, magenta, red, blue, black
    // maps to r = ~idx[1], g = ~idx[2], b = ~idx[0]
    always_comb begin
        if (bar_idx < 10'd8) begin
            bar_rgb = {~bar_idx[1], ~bar_idx[2], ~bar_idx[0]};
        end else begin
            bar_rgb = 3'b000;
        end
    end

    always_comb begin
        case (mode)
            pat_solid: begin
                red_next   = color[23:16];
                green_next = color[15:8];
                blue_next  = color[7:0];
            end
            pat_ramp: begin
                red_next   = hpos[7:0];
                green_next = vpos[7:0];
                blue_next  = hpos[7:0] ^ vpos[7:0];
            end
            default: begin
                // Bars, full intensity
                red_next   = {8{bar_rgb[2]}};
                green_next = {8{bar_rgb[1]}};
                blue_next  = {8{bar_rgb[0]}};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            red   <= red_next;
            green <= green_next;
            blue  <= blue_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/tmds_encoder.sv ====
// ======================================================================
// One TMDS channel. Three pipeline stages turn a byte or a control pair into
// a 10-bit symbol; latency is fixed at three clocks for data and control.
// ======================================================================
`default_nettype none

module tmds_encoder import dvi_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [7:0] data,
    input  wire logic [1:0] ctrl,
    input  wire logic       de,
    output logic [9:0]      symbol
);

    // Stage 1 registers
    logic [7:0]        data_q;
    logic [3:0]        n1_data;
    logic [1:0]        ctrl_q1;
    logic              de_q1;

    // Stage 2 registers
    logic [8:0]        qm_q;
    logic [3:0]        n1_qm;
    logic [3:0]        n0_qm;
    logic [1:0]        ctrl_q2;
    logic              de_q2;

    // Stage 3 state
    logic signed [5:0] disparity;

    logic              use_xnor;
    logic [8:0]        qm;
    logic signed [5:0] bal;
    logic signed [5:0] disp_next;
    logic [9:0]        sym_next;

    // XNOR chain when the byte is ones heavy
    assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !data_q[0]);

    always_comb begin
        qm[0] = data_q[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = use_xnor ? ~(qm[i-1] ^ data_q[i]) : (qm[i-1] ^ data_q[i]);
        end
        // Bit 8 set marks the XOR chain
        qm[8] = ~use_xnor;
    end

    // Ones minus zeros of the minimised byte
    assign bal = $signed({2'b00, n1_qm}) - $signed({2'b00, n0_qm});

    // Balancing against the running disparity
    always_comb begin
        if ((disparity == 6'sd0) || (n1_qm == n0_qm)) begin
            sym_next = {~qm_q[8], qm_q[8], qm_q[8] ? qm_q[7:0] : ~qm_q[7:0]};
            disp_next = qm_q[8] ? (disparity + bal) : (disparity - bal);
        end else if (((disparity > 6'sd0) && (n1_qm > n0_qm)) ||
                     ((disparity < 6'sd0) && (n0_qm > n1_qm))) begin
            // Invert to pull disparity back toward zero
            sym_next  = {1'b1, qm_q[8], ~qm_q[7:0]};
            disp_next = disparity + $signed({4'b0000, qm_q[8], 1'b0}) - bal;
        end else begin
            sym_next  = {1'b0, qm_q[8], qm_q[7:0]};
            disp_next = disparity - $signed({4'b0000, ~qm_q[8], 1'b0}) + bal;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q    <= '0;
            n1_data   <= '0;
            ctrl_q1   <= '0;
            de_q1     <= 1'b0;
            qm_q      <= '0;
            n1_qm     <= '0;
            n0_qm     <= '0;
            ctrl_q2   <= '0;
            de_q2     <= 1'b0;
            disparity <= '0;
            symbol    <= ctl_sym_0;
        end else begin
            // Stage 1 buffers the byte and its ones count
            data_q  <= data;
            n1_data <= 4'($countones(data));
            ctrl_q1 <= ctrl;
            de_q1   <= de;
            // Stage 2
            qm_q    <= qm;
            n1_qm   <= 4'($countones(qm[7:0]));
            n0_qm   <= 4'd8 - 4'($countones(qm[7:0]));
            ctrl_q2 <= ctrl_q1;
            de_q2   <= de_q1;
            // Stage 3, control symbols reset the disparity
            if (de_q2) begin
                symbol    <= sym_next;
                disparity <= disp_next;
            end else begin
                case (ctrl_q2)
                    2'b00:   symbol <= ctl_sym_0;
                    2'b01:   symbol <= ctl_sym_1;
                    2'b10:   symbol <= ctl_sym_2;
                    default: symbol <= ctl_sym_3;
                endcase
                disparity <= '0;
            end
        end
    end

    // Every data symbol shifts the count by an even amount
    a_disp_even: assert property (@(posedge clk) disable iff (!rst_n)
        disparity[0] == 1'b0);

endmodule

`default_nettype wire

// ==== src/dvi_tx_top.sv ====
// ======================================================================
// DVI transmitter front end top level. Three TMDS symbols per pixel clock,
// five clocks after the raster counters hold the pixel's position.
// ======================================================================
`default_nettype none

module dvi_tx_top import dvi_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        cfg_we,
    input  wire reg_addr_t   cfg_addr,
    input  wire logic [23:0] cfg_wdata,
    output logic [9:0]       tmds_red,
    output logic [9:0]       tmds_green,
    output logic [9:0]       tmds_blue
);

    logic [9:0]  hpos;
    logic [9:0]  vpos;
    logic        active;
    logic        hsync;
    logic        vsync;
    pattern_t    mode;
    logic [23:0] color;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;

    // Sync and enable delayed to match the pattern register
    logic        active_d;
    logic        hsync_d;
    logic        vsync_d;

    video_timing u_timing (
        .clk(clk), .rst_n(rst_n), .hpos(hpos), .vpos(vpos),
        .active(active), .hsync(hsync), .vsync(vsync)
    );

    dvi_regs u_regs (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .mode(mode), .color(color)
    );

    pattern_gen u_pattern (
        .clk(clk), .rst_n(rst_n), .hpos(hpos), .vpos(vpos), .mode(mode),
        .color(color), .red(red), .green(green), .blue(blue)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
        end else begin
            active_d <= active;
            hsync_d  <= hsync;
            vsync_d  <= vsync;
        end
    end

    // Blue carries the syncs, red and green send zero control bits
    tmds_encoder u_enc_red (
        .clk(clk), .rst_n(rst_n), .data(red), .ctrl(2'b00),
        .de(active_d), .symbol(tmds_red)
    );
    tmds_encoder u_enc_green (
        .clk(clk), .rst_n(rst_n), .data(green), .ctrl(2'b00),
        .de(active_d), .symbol(tmds_green)
    );
    tmds_encoder u_enc_blue (
        .clk(clk), .rst_n(rst_n), .data(blue), .ctrl({vsync_d, hsync_d}),
        .de(active_d), .symbol(tmds_blue)
    );

    // Blanking at the encoder input shows up as a control symbol later
    a_blank_ctl: assert property (@(posedge clk) disable iff (!rst_n)
        !active_d |-> ##enc_latency (tmds_red == ctl_sym_0));

endmodule

`default_nettype wire

// ==== test/tmds_check.svh ====
// ======================================================================
// TMDS reference functions for the DVI testbench: minimised word, symbol
// decode and the DVI balancing choice for a given running disparity.
// ======================================================================
`ifndef TMDS_CHECK_SVH
`define TMDS_CHECK_SVH

// XOR or XNOR chain picked from the ones count, bit 8 set for XOR
function automatic logic [8:0] minimise_byte(input logic [7:0] d);
    int         ones;
    logic [8:0] q;
    ones = $countones(d);
    q[8] = !((ones > 4) || ((ones == 4) && !d[0]));
    q[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        q[i] = q[8] ? (q[i-1] ^ d[i]) : !(q[i-1] ^ d[i]);
    end
    return q;
endfunction

// Undo the optional inversion, then the chain that bit 8 selects
function automatic logic [7:0] decode_symbol(input logic [9:0] s);
    logic [7:0] w;
    logic [7:0] d;
    w = s[9] ? ~s[7:0] : s[7:0];
    d[0] = w[0];
    for (int i = 1; i < 8; i++) begin
        d[i] = s[8] ? (w[i] ^ w[i-1]) : !(w[i] ^ w[i-1]);
    end
    return d;
endfunction

// Expected {bit 9, bit 8} of the symbol for byte d at disparity rd
function automatic logic [1:0] balance_bits(input logic [7:0] d, input int rd);
    logic [8:0] q;
    int         n1;
    q  = minimise_byte(d);
    n1 = $countones(q[7:0]);
    // Neutral word or neutral line, bit 9 is the inverse of bit 8
    if ((rd == 0) || (n1 == 4)) begin
        return {!q[8], q[8]};
    end
    // Inversion pulls the disparity back toward zero
    if (((rd > 0) && (n1 > 4)) || ((rd < 0) && (n1 < 4))) begin
        return {1'b1, q[8]};
    end
    return {1'b0, q[8]};
endfunction

// Running disparity after sending byte d
function automatic int next_disparity(input logic [7:0] d, input int rd);
    logic [8:0] q;
    int         n1;
    int         diff;
    q    = minimise_byte(d);
    n1   = $countones(q[7:0]);
    // Ones minus zeros of the low byte
    diff = 2 * n1 - 8;
    if ((rd == 0) || (n1 == 4)) begin
        return q[8] ? (rd + diff) : (rd - diff);
    end
    if (((rd > 0) && (n1 > 4)) || ((rd < 0) && (n1 < 4))) begin
        return rd + (q[8] ? 2 : 0) - diff;
    end
    return rd - (q[8] ? 0 : 2) + diff;
endfunction

`endif

// ==== test/tb_dvi_tx.sv ====
// ======================================================================
// Testbench for the DVI transmitter. Runs whole frames per table entry and
// checks every TMDS symbol against a prediction from its own raster count.
// ======================================================================
`default_nettype none

module tb_dvi_tx import dvi_pkg::*; ();

    `include "tmds_check.svh"

    localparam int n_tests    = 5;
    localparam int max_prints = 40;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cfg_we;
    reg_addr_t   cfg_addr;
    logic [23:0] cfg_wdata;
    logic [9:0]  tmds_red;
    logic [9:0]  tmds_green;
    logic [9:0]  tmds_blue;

    // Stimulus table with one row per test
    string       tst_name   [n_tests];
    logic [1:0]  tst_mode   [n_tests];
    logic [23:0] tst_color  [n_tests];
    int          tst_frames [n_tests];

    // Configuration that the DUT should be showing
    pattern_t    exp_mode;
    logic [23:0] exp_color;
    // Running disparity per channel in red, green, blue order
    int          disp [3];
    string       ch_name [3] = '{"red", "green", "blue"};

    int          cur_test;
    int          test_errors;
    int          test_checks;
    int          total_errors = 0;
    int          total_checks = 0;
    int          failed_tests = 0;
    int          printed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    dvi_tx_top uut (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .tmds_red(tmds_red), .tmds_green(tmds_green),
        .tmds_blue(tmds_blue)
    );

    always #10 clk = ~clk;

    // Watchdog on the clock count against the limit from the table
    always @(posedge clk) begin
        cycle_count++;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
            $display("Timeout: no end of test after %0d clocks", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Control symbol for the blue channel indexed by {vsync, hsync}
    function automatic logic [9:0] control_symbol(input logic vs, input logic hs);
        case ({vs, hs})
            2'b00:   return ctl_sym_0;
            2'b01:   return ctl_sym_1;
            2'b10:   return ctl_sym_2;
            default: return ctl_sym_3;
        endcase
    endfunction

    // Expected {red, green, blue} at visible position (h, v)
    function automatic logic [23:0] predict_pixel(input pattern_t m, input logic [23:0] c,
                                                  input int h, input int v);
        case (m)
            pat_solid: return c;
            pat_ramp:  return {8'(h), 8'(v), 8'(h) ^ 8'(v)};
            default: begin
                // White yellow cyan green magenta red blue black
                case (h / int'(bar_width))
                    0:       return 24'hffffff;
                    1:       return 24'hffff00;
                    2:       return 24'h00ffff;
                    3:       return 24'h00ff00;
                    4:       return 24'hff00ff;
                    5:       return 24'hff0000;
                    6:       return 24'h0000ff;
                    default: return 24'h000000;
                endcase
            end
        endcase
    endfunction

    // Solid colours come from the LCG
    // Mode 3 is an illegal code
    task automatic build_table();
        logic [31:0] seed;
        seed = 32'hdf0f9a04;
        tst_name[0] = "reset_bars";
        tst_mode[0] = 2'(pat_bars);
        tst_color[0] = 24'h000000;
        seed = lcg_next(seed);
        tst_name[1] = "ramp";
        tst_mode[1] = 2'(pat_ramp);
        tst_color[1] = seed[31:8];
        seed = lcg_next(seed);
        tst_name[2] = "solid";
        tst_mode[2] = 2'(pat_solid);
        tst_color[2] = seed[31:8];
        seed = lcg_next(seed);
        tst_name[3] = "invalid_mode";
        tst_mode[3] = 2'd3;
        tst_color[3] = seed[31:8];
        tst_name[4] = "bars_again";
        tst_mode[4] = 2'(pat_bars);
        tst_color[4] = seed[31:8];
        for (int i = 0; i < n_tests; i++) begin
            tst_frames[i] = 1;
        end
    endtask

    task automatic report_mismatch(input string what, input int h, input int v,
                                   input logic [9:0] expected, input logic [9:0] actual);
        test_errors++;
        total_errors++;
        if (printed < max_prints) begin
            $display("** Error %s: %s at (%0d,%0d) expected %h actual %h",
                     tst_name[cur_test], what, h, v, expected, actual);
            printed++;
        end else if (printed == max_prints) begin
            $display("Further error lines suppressed");
            printed++;
        end
    endtask

    // Two writes on the third blanking line hand over the next test's setup
    task automatic drive_config(input int next, input int h, input int v);
        if (v == int'(v_active) + 2) begin
            if (h == 0) begin
                cfg_we    = 1'b1;
                cfg_addr  = addr_mode;
                cfg_wdata = {22'd0, tst_mode[next]};
            end else if (h == 1) begin
                cfg_addr  = addr_color;
                cfg_wdata = tst_color[next];
            end else if (h == 2) begin
                cfg_we    = 1'b0;
            end
        end
    endtask

    task automatic check_position(input int h, input int v);
        logic [9:0] sym [3];
        logic [7:0] want [3];
        logic [23:0] pix;
        logic [8:0] qm;
        logic [7:0] got;
        logic [1:0] bal;
        logic       hs;
        logic       vs;
        sym[0] = tmds_red;
        sym[1] = tmds_green;
        sym[2] = tmds_blue;
        hs = (h >= int'(h_sync_start)) && (h < int'(h_sync_end));
        vs = (v >= int'(v_sync_start)) && (v < int'(v_sync_end));
        test_checks += 3;
        if ((h >= int'(h_active)) || (v >= int'(v_active))) begin
            // Each active run starts from zero disparity
            for (int ch = 0; ch < 3; ch++) begin
                disp[ch] = 0;
            end
            if (tmds_red !== ctl_sym_0) begin
                report_mismatch("red control", h, v, ctl_sym_0, tmds_red);
            end
            if (tmds_green !== ctl_sym_0) begin
                report_mismatch("green control", h, v, ctl_sym_0, tmds_green);
            end
            if (tmds_blue !== control_symbol(vs, hs)) begin
                report_mismatch("blue control", h, v, control_symbol(vs, hs), tmds_blue);
            end
        end else begin
            pix = predict_pixel(exp_mode, exp_color, h, v);
            want[0] = pix[23:16];
            want[1] = pix[15:8];
            want[2] = pix[7:0];
            for (int ch = 0; ch < 3; ch++) begin
                got = decode_symbol(sym[ch]);
                qm  = minimise_byte(want[ch]);
                bal = balance_bits(got, disp[ch]);
                if (got !== want[ch]) begin
                    report_mismatch({ch_name[ch], " data"}, h, v,
                                    {2'b00, want[ch]}, {2'b00, got});
                end
                if (sym[ch][8] !== qm[8]) begin
                    report_mismatch({ch_name[ch], " bit 8"}, h, v,
                                    {9'd0, qm[8]}, {9'd0, sym[ch][8]});
                end
                if (sym[ch][9:8] !== bal) begin
                    report_mismatch({ch_name[ch], " bits 9:8"}, h, v,
                                    {8'd0, bal}, {8'd0, sym[ch][9:8]});
                end
                disp[ch] = next_disparity(got, disp[ch]);
            end
        end
    endtask

    // One full raster of symbols, which lag the DUT counters by 5 clocks
    task automatic run_frame(input int idx, input bit write_next);
        for (int v = 0; v < int'(v_total); v++) begin
            for (int h = 0; h < int'(h_total); h++) begin
                @(posedge clk);
                #1;
                if (write_next) begin
                    drive_config(idx + 1, h, v);
                end
                check_position(h, v);
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = addr_mode;
        cfg_wdata = '0;
        build_table();
        cycle_limit = 1000;
        for (int i = 0; i < n_tests; i++) begin
            cycle_limit += tst_frames[i] * int'(h_total) * int'(v_total);
        end
        exp_mode  = pat_bars;
        exp_color = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Timing, pattern and encoder registers fill before (0, 0) shows
        repeat (enc_latency + 1) @(posedge clk);
        for (int i = 0; i < n_tests; i++) begin
            cur_test    = i;
            test_errors = 0;
            test_checks = 0;
            // Illegal mode code leaves the previous pattern in force
            if (tst_mode[i] <= 2'd2) begin
                exp_mode = pattern_t'(tst_mode[i]);
            end
            exp_color = tst_color[i];
            for (int f = 0; f < tst_frames[i]; f++) begin
                run_frame(i, (f == tst_frames[i] - 1) && (i + 1 < n_tests));
            end
            total_checks += test_checks;
            if (test_errors != 0) begin
                failed_tests++;
            end
            $display("Test %s: %0d symbols checked, %0d errors", tst_name[i], test_checks,
                     test_errors);
        end
        $display("Summary: %0d tests, %0d failed, %0d symbols checked, %0d errors",
                 n_tests, failed_tests, total_checks, total_errors);
        if ((total_errors == 0) && (total_checks > 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+test
src/dvi_pkg.sv
src/video_timing.sv
src/dvi_regs.sv
src/pattern_gen.sv
src/tmds_encoder.sv
src/dvi_tx_top.sv
test/tb_dvi_tx.sv

// ==== Makefile ====
# Verilator flow for the DVI transmitter testbench
TOP = tb_dvi_tx

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
